// File: microcode_control.f
source/microcode_pkg.sv
source/instruction_buffer.sv
source/address_mapper.sv
source/microcode_rom.sv
source/micro_sequencer.sv
source/microcode_control.sv
bench/microcode_control_tb.sv

// File: Bender.yml
package:
  name: microcode_control

sources:
  - target: any(rtl, test)
    files:
      - source/microcode_pkg.sv
      - source/instruction_buffer.sv
      - source/address_mapper.sv
      - source/microcode_rom.sv
      - source/micro_sequencer.sv
      - source/microcode_control.sv
  - target: test
    files:
      - bench/microcode_control_tb.sv

// File: bench/microcode_control_tb.sv
module microcode_control_tb;

    localparam int BUFFER_DEPTH = 4;
    localparam int CTRL_CREDITS = 2;
    // {opcode, funct3, funct7} of every legal encoding, index i has entry address i + 1
    localparam logic [28:0][16:0] LEGAL = {
        {7'h33, 3'd6, 7'h01}, {7'h33, 3'd4, 7'h01}, {7'h33, 3'd0, 7'h01}, {7'h67, 3'd0, 7'h00},
        {7'h6f, 3'd0, 7'h00}, {7'h17, 3'd0, 7'h00}, {7'h37, 3'd0, 7'h00}, {7'h13, 3'd5, 7'h20},
        {7'h13, 3'd5, 7'h00}, {7'h13, 3'd1, 7'h00}, {7'h13, 3'd7, 7'h00}, {7'h13, 3'd6, 7'h00},
        {7'h13, 3'd4, 7'h00}, {7'h13, 3'd3, 7'h00}, {7'h13, 3'd2, 7'h00}, {7'h13, 3'd0, 7'h00},
        {7'h63, 3'd0, 7'h00}, {7'h23, 3'd2, 7'h00}, {7'h03, 3'd2, 7'h00}, {7'h33, 3'd3, 7'h00},
        {7'h33, 3'd2, 7'h00}, {7'h33, 3'd5, 7'h20}, {7'h33, 3'd5, 7'h00}, {7'h33, 3'd1, 7'h00},
        {7'h33, 3'd4, 7'h00}, {7'h33, 3'd6, 7'h00}, {7'h33, 3'd7, 7'h00}, {7'h33, 3'd0, 7'h20},
        {7'h33, 3'd0, 7'h00}};

    logic clk;
    logic reset;
    logic inst_valid;
    logic ctrl_credit;
    logic inst_credit;
    logic ctrl_valid;
    logic withhold;
    microcode_pkg::instruction_word_t inst;
    microcode_pkg::ctrl_word_t        ctrl;

    logic [31:0]               tx_q[$];     // Waiting for a fetch credit
    logic [31:0]               check_q[$];  // Sent, not yet checked
    microcode_pkg::ctrl_word_t rx_q[$];
    int pushed_total, credits_total, owed, expected_words;
    int errors, checks, tests, test_errors;
    string test_name;

    microcode_control #(
        .BUFFER_DEPTH(BUFFER_DEPTH),
        .CTRL_CREDITS(CTRL_CREDITS)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ctrl_credit(ctrl_credit),
        .inst_credit(inst_credit),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin  // Fetch stage, pushes only while holding a credit
        if (!reset && tx_q.size() > 0 && (BUFFER_DEPTH - pushed_total + credits_total) > 0) begin
            inst_valid <= 1'b1;
            inst       <= tx_q.pop_front();
            pushed_total++;
        end else begin
            inst_valid <= 1'b0;
        end
    end

    always @(posedge clk) begin  // Datapath returns one credit per received word
        if (!reset && !withhold && owed > 0) begin
            ctrl_credit <= 1'b1;
            owed--;
        end else begin
            ctrl_credit <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (ctrl_valid) begin
                rx_q.push_back(ctrl);
                owed++;
            end
            if (inst_credit) credits_total++;
        end
    end

    function automatic logic [5:0] entry_of(input logic [31:0] w);
        entry_of = 6'd63;
        if (w[6:0] == 7'h33) begin
            case ({w[31:25], w[14:12]})
                {7'h00, 3'd0}: entry_of = 6'd1;
                {7'h20, 3'd0}: entry_of = 6'd2;
                {7'h00, 3'd7}: entry_of = 6'd3;
                {7'h00, 3'd6}: entry_of = 6'd4;
                {7'h00, 3'd4}: entry_of = 6'd5;
                {7'h00, 3'd1}: entry_of = 6'd6;
                {7'h00, 3'd5}: entry_of = 6'd7;
                {7'h20, 3'd5}: entry_of = 6'd8;
                {7'h00, 3'd2}: entry_of = 6'd9;
                {7'h00, 3'd3}: entry_of = 6'd10;
                {7'h01, 3'd0}: entry_of = 6'd27;
                {7'h01, 3'd4}: entry_of = 6'd28;
                {7'h01, 3'd6}: entry_of = 6'd29;
                default:       entry_of = 6'd63;
            endcase
        end else if (w[6:0] == 7'h13) begin
            case (w[14:12])
                3'd0: entry_of = 6'd14;
                3'd1: entry_of = 6'd20;
                3'd2: entry_of = 6'd15;
                3'd3: entry_of = 6'd16;
                3'd4: entry_of = 6'd17;
                3'd6: entry_of = 6'd18;
                3'd7: entry_of = 6'd19;
                default: entry_of = (w[31:25] == 7'h00) ? 6'd21 : (w[31:25] == 7'h20) ? 6'd22 : 6'd63;
            endcase
        end else begin
            case (w[6:0])
                7'h03: entry_of = 6'd11;
                7'h23: entry_of = 6'd12;
                7'h63: entry_of = 6'd13;
                7'h37: entry_of = 6'd23;
                7'h17: entry_of = 6'd24;
                7'h6f: entry_of = 6'd25;
                7'h67: entry_of = 6'd26;
                default: entry_of = 6'd63;
            endcase
        end
    endfunction

    function automatic int word_count_of(input logic [5:0] entry);
        if (entry >= 6'd27 && entry <= 6'd29) return 3;
        if ((entry >= 6'd11 && entry <= 6'd13) || entry == 6'd25 || entry == 6'd26) return 2;
        return 1;
    endfunction

    function automatic logic [5:0] step_address(input logic [5:0] entry, input int k);
        if (k == 0) return entry;
        case (entry)
            6'd11: return 6'd32;
            6'd12: return 6'd33;
            6'd13: return 6'd34;
            6'd25: return 6'd35;
            6'd26: return 6'd36;
            6'd27: return (k == 1) ? 6'd37 : 6'd38;
            6'd28: return (k == 1) ? 6'd39 : 6'd40;
            default: return (k == 1) ? 6'd41 : 6'd42;  // REM
        endcase
    endfunction

    function automatic logic [31:0] make_word(input logic [6:0] op, input logic [2:0] f3,
                                              input logic [6:0] f7);
        return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), op};
    endfunction

    function automatic logic [31:0] imm_word(input logic [6:0] op, input logic [2:0] f3);
        return {12'($urandom), 5'($urandom), f3, 5'($urandom), op};
    endfunction

    task automatic compare_value(input string field, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("[FAIL] %s: %s expected %0d actual %0d", test_name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) $display("ALL CHECKS PASSED");
        else $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic start_test(input string name);
        @(negedge clk);
        test_name   = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == test_errors) $display("test %s: passed", test_name);
        else $display("test %s: %0d errors", test_name, errors - test_errors);
    endtask

    task automatic issue(input logic [31:0] w);
        tx_q.push_back(w);
        check_q.push_back(w);
        expected_words += word_count_of(entry_of(w));
    endtask

    task automatic wait_for_words(input int target);
        int waited;
        waited = 0;
        while (rx_q.size() < target && waited < 400) begin
            @(posedge clk);
            waited++;
        end
        if (rx_q.size() < target) begin
            $display("Timeout in %s: only %0d of %0d control words arrived",
                     test_name, rx_q.size(), target);
            errors++;
            finish_run();
        end
    endtask

    task automatic verify_sequence(input logic [31:0] w);
        logic [5:0]                entry;
        int                        n;
        microcode_pkg::ctrl_word_t c;
        entry = entry_of(w);
        n     = word_count_of(entry);
        for (int k = 0; k < n; k++) begin
            if (rx_q.size() == 0) begin
                $display("%s: control word %0d of instruction %08h never arrived", test_name, k, w);
                errors++;
                return;
            end
            c = rx_q.pop_front();
            compare_value("micro_address", step_address(entry, k), c.micro_address);
            compare_value("last", k == n - 1, c.uop.last);
            compare_value("trap", entry == 6'd63, c.uop.trap);
            compare_value("rd", w[11:7], c.rd);
            compare_value("rs1", w[19:15], c.rs1);
            if (k == 0 && ((entry >= 6'd14 && entry <= 6'd22) || entry == 6'd11))
                compare_value("operand_b imm12", w[31:20], c.operand_b);
            else if (k == 0 && (entry <= 6'd10 || (entry >= 6'd27 && entry <= 6'd29)))
                compare_value("operand_b rs2", w[24:20], c.operand_b);
        end
    endtask

    task automatic drain();
        wait_for_words(expected_words);
        repeat (6) @(posedge clk);  // Room for stray extra words
        compare_value("word count", expected_words, rx_q.size());
        while (check_q.size() > 0) verify_sequence(check_q.pop_front());
        rx_q.delete();
        expected_words = 0;
    endtask

    task automatic idle_after_reset();
        start_test("reset_state");
        repeat (10) begin
            @(negedge clk);
            compare_value("ctrl_valid", 0, ctrl_valid);
            compare_value("inst_credit", 0, inst_credit);
        end
        end_test();
    endtask

    task automatic legal_encodings();
        logic [16:0] e;
        start_test("legal_encodings");
        for (int i = 0; i < 29; i++) begin
            e = LEGAL[i];
            issue(make_word(e[16:10], e[9:7], e[6:0]));
        end
        drain();
        end_test();
    endtask

    task automatic illegal_encodings();
        start_test("illegal_encodings");
        issue(make_word(7'h7f, 3'd0, 7'h00));  // Unknown opcode
        issue(make_word(7'h33, 3'd0, 7'h10));  // ADD, bad funct7
        issue(make_word(7'h33, 3'd5, 7'h01));  // SRL, bad funct7
        issue(make_word(7'h13, 3'd5, 7'h10));  // SRAI, bad funct7
        drain();
        end_test();
    endtask

    task automatic operand_decode();
        start_test("operand_decode");
        repeat (4) begin
            issue(imm_word(7'h13, 3'd0));
            issue(imm_word(7'h13, 3'd4));
            issue(imm_word(7'h03, 3'd2));
            issue(make_word(7'h33, 3'd0, 7'h00));
            issue(make_word(7'h33, 3'd7, 7'h00));
        end
        drain();
        end_test();
    endtask

    task automatic back_pressure();
        start_test("back_pressure");
        withhold = 1'b1;
        issue(make_word(7'h33, 3'd0, 7'h01));  // MUL, three words
        issue(make_word(7'h33, 3'd0, 7'h00));
        wait_for_words(CTRL_CREDITS);
        repeat (10) @(posedge clk);
        compare_value("words while withheld", CTRL_CREDITS, rx_q.size());
        @(negedge clk);
        withhold = 1'b0;
        drain();
        end_test();
    endtask

    task automatic upstream_credits();
        int base;
        start_test("upstream_credits");
        base = credits_total;
        issue(make_word(7'h33, 3'd0, 7'h00));
        issue(imm_word(7'h03, 3'd2));
        issue(make_word(7'h33, 3'd4, 7'h01));
        issue(imm_word(7'h13, 3'd4));
        issue(make_word(7'h6f, 3'd0, 7'h00));
        issue(make_word(7'h33, 3'd6, 7'h00));
        drain();
        compare_value("inst_credit pulses", 6, credits_total - base);
        end_test();
    endtask

    initial begin
        void'($urandom(99602));
        reset          = 1'b1;
        inst_valid     = 1'b0;
        inst           = '0;
        ctrl_credit    = 1'b0;
        withhold       = 1'b0;
        pushed_total   = 0;
        credits_total  = 0;
        owed           = 0;
        expected_words = 0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        idle_after_reset();
        legal_encodings();
        illegal_encodings();
        operand_decode();
        back_pressure();
        upstream_credits();
        finish_run();
    end

endmodule

// File: source/microcode_control.sv
module microcode_control #(
    parameter int BUFFER_DEPTH = 4,
    parameter int CTRL_CREDITS = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             inst_valid,
    input  microcode_pkg::instruction_word_t inst,
    input  logic                             ctrl_credit,
    output logic                             inst_credit,
    output logic                             ctrl_valid,
    output microcode_pkg::ctrl_word_t        ctrl
);

    microcode_pkg::instruction_word_t head;
    microcode_pkg::micro_addr_t       entry_address;
    microcode_pkg::micro_addr_t       rom_address;
    microcode_pkg::micro_instr_t      micro_instr;
    logic                             not_empty;
    logic                             pop;

    instruction_buffer #(
        .BUFFER_DEPTH(BUFFER_DEPTH)
    ) u_buffer (
        .clk          (clk),
        .reset        (reset),
        .push         (inst_valid),
        .push_word    (inst),
        .pop          (pop),
        .head         (head),
        .not_empty    (not_empty),
        .credit_return(inst_credit)
    );

    address_mapper u_mapper (
        .opcode       (head.r_view.opcode),
        .funct3       (head.r_view.funct3),
        .funct7       (head.r_view.funct7),
        .entry_address(entry_address)
    );

    microcode_rom u_rom (
        .address    (rom_address),
        .micro_instr(micro_instr)
    );

    micro_sequencer #(
        .CTRL_CREDITS(CTRL_CREDITS)
    ) u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .head         (head),
        .not_empty    (not_empty),
        .entry_address(entry_address),
        .micro_instr  (micro_instr),
        .ctrl_credit  (ctrl_credit),
        .pop          (pop),
        .rom_address  (rom_address),
        .ctrl_valid   (ctrl_valid),
        .ctrl         (ctrl)
    );

endmodule

// File: source/micro_sequencer.sv
module micro_sequencer #(
    parameter int CTRL_CREDITS = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  microcode_pkg::instruction_word_t head,
    input  logic                             not_empty,
    input  microcode_pkg::micro_addr_t       entry_address,
    input  microcode_pkg::micro_instr_t      micro_instr,
    input  logic                             ctrl_credit,
    output logic                             pop,
    output microcode_pkg::micro_addr_t       rom_address,
    output logic                             ctrl_valid,
    output microcode_pkg::ctrl_word_t        ctrl
);

    localparam int CRED_W = $clog2(CTRL_CREDITS + 1);

    microcode_pkg::micro_addr_t       upc;
    microcode_pkg::instruction_word_t latched;
    microcode_pkg::ctrl_word_t        ctrl_next;
    logic                             busy;
    logic [CRED_W-1:0]                credits;
    logic [CRED_W-1:0]                outstanding;  // Words on the bus not yet paid back
    logic                             have_credit;
    logic                             emit;
    logic                             dispatch;

    assign have_credit = (credits != '0);
    assign emit        = busy && have_credit;
    // Next dispatch overlaps the last micro-op of the current one
    assign dispatch    = have_credit && not_empty && (!busy || micro_instr.last);
    assign pop         = dispatch;
    assign rom_address = upc;

    always_comb begin
        ctrl_next.micro_address = upc;
        ctrl_next.uop           = micro_instr;
        ctrl_next.rd            = latched.r_view.rd;
        ctrl_next.rs1           = latched.r_view.rs1;
        if (micro_instr.src_b_imm) begin
            ctrl_next.operand_b = latched.i_view.imm12;
        end else begin
            ctrl_next.operand_b = {7'b0, latched.r_view.rs2};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            upc         <= microcode_pkg::UADDR_NOP;
            busy        <= 1'b0;
            ctrl_valid  <= 1'b0;
            credits     <= CRED_W'(CTRL_CREDITS);
            outstanding <= '0;
        end else begin
            ctrl_valid <= emit;
            if (dispatch) begin
                upc  <= entry_address;
                busy <= 1'b1;
            end else if (emit) begin
                upc  <= micro_instr.next_address;
                busy <= !micro_instr.last;  // Go idle when nothing is queued
            end
            case ({emit, ctrl_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // Spend and return cancel
            endcase
            case ({ctrl_valid, ctrl_credit})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            latched <= head;
        end
        if (emit) begin
            ctrl <= ctrl_next;
        end
    end

    // The datapath never holds more than CTRL_CREDITS unanswered words
    assert property (@(posedge clk) disable iff (reset)
        ctrl_valid |-> outstanding < CTRL_CREDITS);
    assert property (@(posedge clk) disable iff (reset) credits <= CTRL_CREDITS);

endmodule

// File: source/microcode_rom.sv
module microcode_rom (
    input  microcode_pkg::micro_addr_t  address,
    output microcode_pkg::micro_instr_t micro_instr
);

    // Flag order follows the struct: src_b_imm reg_write mem_read mem_write branch jump trap
    localparam logic [6:0] F_NONE = 7'b0000000;
    localparam logic [6:0] F_IMM  = 7'b1000000;
    localparam logic [6:0] F_RW   = 7'b0100000;
    localparam logic [6:0] F_MRD  = 7'b0010000;
    localparam logic [6:0] F_MWR  = 7'b0001000;
    localparam logic [6:0] F_BR   = 7'b0000100;
    localparam logic [6:0] F_JMP  = 7'b0000010;
    localparam logic [6:0] F_TRAP = 7'b0000001;

    function automatic microcode_pkg::micro_instr_t uop(
        input microcode_pkg::alu_op_t     op,
        input logic [6:0]                 flags,
        input logic                       last,
        input microcode_pkg::micro_addr_t next
    );
        return {op, flags, last, next};
    endfunction

    always_comb begin
        case (address)
            microcode_pkg::UADDR_NOP:  micro_instr = uop(microcode_pkg::ALU_PASS, F_NONE, 1'b1, '0);
            microcode_pkg::UADDR_ADD:  micro_instr = uop(microcode_pkg::ALU_ADD, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SUB:  micro_instr = uop(microcode_pkg::ALU_SUB, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_AND:  micro_instr = uop(microcode_pkg::ALU_AND, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_OR:   micro_instr = uop(microcode_pkg::ALU_OR, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_XOR:  micro_instr = uop(microcode_pkg::ALU_XOR, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SLL:  micro_instr = uop(microcode_pkg::ALU_SLL, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SRL:  micro_instr = uop(microcode_pkg::ALU_SRL, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SRA:  micro_instr = uop(microcode_pkg::ALU_SRA, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SLT:  micro_instr = uop(microcode_pkg::ALU_SLT, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SLTU: micro_instr = uop(microcode_pkg::ALU_SLTU, F_RW, 1'b1, '0);
            // Address generation first, then the memory access
            microcode_pkg::UADDR_LOAD:
                micro_instr = uop(microcode_pkg::ALU_ADD, F_IMM, 1'b0, microcode_pkg::UADDR_LOAD_2);
            microcode_pkg::UADDR_LOAD_2:
                micro_instr = uop(microcode_pkg::ALU_PASS, F_MRD | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_STORE:
                micro_instr = uop(microcode_pkg::ALU_ADD, F_IMM, 1'b0, microcode_pkg::UADDR_STORE_2);
            microcode_pkg::UADDR_STORE_2:
                micro_instr = uop(microcode_pkg::ALU_PASS, F_MWR, 1'b1, '0);
            // Compare, then target add
            microcode_pkg::UADDR_BRANCH:
                micro_instr = uop(microcode_pkg::ALU_SUB, F_NONE, 1'b0, microcode_pkg::UADDR_BRANCH_2);
            microcode_pkg::UADDR_BRANCH_2:
                micro_instr = uop(microcode_pkg::ALU_ADD, F_IMM | F_BR, 1'b1, '0);
            microcode_pkg::UADDR_ADDI:  micro_instr = uop(microcode_pkg::ALU_ADD, F_IMM | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SLTI:  micro_instr = uop(microcode_pkg::ALU_SLT, F_IMM | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SLTIU: micro_instr = uop(microcode_pkg::ALU_SLTU, F_IMM | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_XORI:  micro_instr = uop(microcode_pkg::ALU_XOR, F_IMM | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_ORI:   micro_instr = uop(microcode_pkg::ALU_OR, F_IMM | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_ANDI:  micro_instr = uop(microcode_pkg::ALU_AND, F_IMM | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SLLI:  micro_instr = uop(microcode_pkg::ALU_SLL, F_IMM | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SRLI:  micro_instr = uop(microcode_pkg::ALU_SRL, F_IMM | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_SRAI:  micro_instr = uop(microcode_pkg::ALU_SRA, F_IMM | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_LUI:   micro_instr = uop(microcode_pkg::ALU_PASS, F_IMM | F_RW, 1'b1, '0);
            microcode_pkg::UADDR_AUIPC: micro_instr = uop(microcode_pkg::ALU_ADD, F_IMM | F_RW, 1'b1, '0);
            // Link write, then the jump itself
            microcode_pkg::UADDR_JAL:
                micro_instr = uop(microcode_pkg::ALU_ADD, F_RW, 1'b0, microcode_pkg::UADDR_JAL_2);
            microcode_pkg::UADDR_JAL_2:
                micro_instr = uop(microcode_pkg::ALU_ADD, F_IMM | F_JMP, 1'b1, '0);
            microcode_pkg::UADDR_JALR:
                micro_instr = uop(microcode_pkg::ALU_ADD, F_RW, 1'b0, microcode_pkg::UADDR_JALR_2);
            microcode_pkg::UADDR_JALR_2:
                micro_instr = uop(microcode_pkg::ALU_ADD, F_IMM | F_JMP, 1'b1, '0);
            // Multi-cycle M ops, result written on the third word
            microcode_pkg::UADDR_MUL:
                micro_instr = uop(microcode_pkg::ALU_MUL, F_NONE, 1'b0, microcode_pkg::UADDR_MUL_2);
            microcode_pkg::UADDR_MUL_2:
                micro_instr = uop(microcode_pkg::ALU_MUL, F_NONE, 1'b0, microcode_pkg::UADDR_MUL_3);
            microcode_pkg::UADDR_MUL_3:
                micro_instr = uop(microcode_pkg::ALU_PASS, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_DIV:
                micro_instr = uop(microcode_pkg::ALU_DIV, F_NONE, 1'b0, microcode_pkg::UADDR_DIV_2);
            microcode_pkg::UADDR_DIV_2:
                micro_instr = uop(microcode_pkg::ALU_DIV, F_NONE, 1'b0, microcode_pkg::UADDR_DIV_3);
            microcode_pkg::UADDR_DIV_3:
                micro_instr = uop(microcode_pkg::ALU_PASS, F_RW, 1'b1, '0);
            microcode_pkg::UADDR_REM:
                micro_instr = uop(microcode_pkg::ALU_REM, F_NONE, 1'b0, microcode_pkg::UADDR_REM_2);
            microcode_pkg::UADDR_REM_2:
                micro_instr = uop(microcode_pkg::ALU_REM, F_NONE, 1'b0, microcode_pkg::UADDR_REM_3);
            microcode_pkg::UADDR_REM_3:
                micro_instr = uop(microcode_pkg::ALU_PASS, F_RW, 1'b1, '0);
            default: micro_instr = uop(microcode_pkg::ALU_PASS, F_TRAP, 1'b1, '0);  // Includes 63
        endcase
    end

endmodule

// File: source/address_mapper.sv
module address_mapper (
    input  logic [6:0]                opcode,
    input  logic [2:0]                funct3,
    input  logic [6:0]                funct7,
    output microcode_pkg::micro_addr_t entry_address
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA
    localparam logic [6:0] F7_MEXT = 7'b0000001;  // M extension

    always_comb begin
        entry_address = microcode_pkg::UADDR_TRAP;  // Anything not matched below
        case (opcode)
            7'b0110011: begin  // R-type
                case (funct3)
                    3'b000: begin
                        if (funct7 == F7_BASE)      entry_address = microcode_pkg::UADDR_ADD;
                        else if (funct7 == F7_ALT)  entry_address = microcode_pkg::UADDR_SUB;
                        else if (funct7 == F7_MEXT) entry_address = microcode_pkg::UADDR_MUL;
                    end
                    3'b100: begin
                        if (funct7 == F7_BASE)      entry_address = microcode_pkg::UADDR_XOR;
                        else if (funct7 == F7_MEXT) entry_address = microcode_pkg::UADDR_DIV;
                    end
                    3'b110: begin
                        if (funct7 == F7_BASE)      entry_address = microcode_pkg::UADDR_OR;
                        else if (funct7 == F7_MEXT) entry_address = microcode_pkg::UADDR_REM;
                    end
                    3'b101: begin
                        if (funct7 == F7_BASE)     entry_address = microcode_pkg::UADDR_SRL;
                        else if (funct7 == F7_ALT) entry_address = microcode_pkg::UADDR_SRA;
                    end
                    3'b111: if (funct7 == F7_BASE) entry_address = microcode_pkg::UADDR_AND;
                    3'b001: if (funct7 == F7_BASE) entry_address = microcode_pkg::UADDR_SLL;
                    3'b010: if (funct7 == F7_BASE) entry_address = microcode_pkg::UADDR_SLT;
                    3'b011: if (funct7 == F7_BASE) entry_address = microcode_pkg::UADDR_SLTU;
                    default: entry_address = microcode_pkg::UADDR_TRAP;
                endcase
            end
            7'b0010011: begin  // ALU with immediate
                case (funct3)
                    3'b000: entry_address = microcode_pkg::UADDR_ADDI;
                    3'b010: entry_address = microcode_pkg::UADDR_SLTI;
                    3'b011: entry_address = microcode_pkg::UADDR_SLTIU;
                    3'b100: entry_address = microcode_pkg::UADDR_XORI;
                    3'b110: entry_address = microcode_pkg::UADDR_ORI;
                    3'b111: entry_address = microcode_pkg::UADDR_ANDI;
                    3'b001: entry_address = microcode_pkg::UADDR_SLLI;
                    3'b101: begin
                        if (funct7 == F7_BASE)     entry_address = microcode_pkg::UADDR_SRLI;
                        else if (funct7 == F7_ALT) entry_address = microcode_pkg::UADDR_SRAI;
                    end
                    default: entry_address = microcode_pkg::UADDR_TRAP;
                endcase
            end
            7'b0000011: entry_address = microcode_pkg::UADDR_LOAD;
            7'b0100011: entry_address = microcode_pkg::UADDR_STORE;
            7'b1100011: entry_address = microcode_pkg::UADDR_BRANCH;  // All six compares
            7'b0110111: entry_address = microcode_pkg::UADDR_LUI;
            7'b0010111: entry_address = microcode_pkg::UADDR_AUIPC;
            7'b1101111: entry_address = microcode_pkg::UADDR_JAL;
            7'b1100111: entry_address = microcode_pkg::UADDR_JALR;
            default:    entry_address = microcode_pkg::UADDR_TRAP;
        endcase
    end

endmodule

// File: source/instruction_buffer.sv
module instruction_buffer #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            push,
    input  microcode_pkg::instruction_word_t push_word,
    input  logic                            pop,
    output microcode_pkg::instruction_word_t head,
    output logic                            not_empty,
    output logic                            credit_return
);

    localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

    microcode_pkg::instruction_word_t mem [BUFFER_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(BUFFER_DEPTH));
    assign head      = mem[rd_ptr];  // Visible the cycle after the write

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;  // One credit back per consumed word
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // Fetch holds a credit for every push, so overflow means lost credits
    assert property (@(posedge clk) disable iff (reset) push |-> !full);
    assert property (@(posedge clk) disable iff (reset) pop |-> not_empty);

endmodule

// File: source/microcode_pkg.sv
package microcode_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instruction_word_t;

    typedef logic [5:0] micro_addr_t;

    // Entry points, one per decoded instruction
    localparam micro_addr_t UADDR_NOP    = 6'd0;  // Never dispatched
    localparam micro_addr_t UADDR_ADD    = 6'd1;
    localparam micro_addr_t UADDR_SUB    = 6'd2;
    localparam micro_addr_t UADDR_AND    = 6'd3;
    localparam micro_addr_t UADDR_OR     = 6'd4;
    localparam micro_addr_t UADDR_XOR    = 6'd5;
    localparam micro_addr_t UADDR_SLL    = 6'd6;
    localparam micro_addr_t UADDR_SRL    = 6'd7;
    localparam micro_addr_t UADDR_SRA    = 6'd8;
    localparam micro_addr_t UADDR_SLT    = 6'd9;
    localparam micro_addr_t UADDR_SLTU   = 6'd10;
    localparam micro_addr_t UADDR_LOAD   = 6'd11;
    localparam micro_addr_t UADDR_STORE  = 6'd12;
    localparam micro_addr_t UADDR_BRANCH = 6'd13;
    localparam micro_addr_t UADDR_ADDI   = 6'd14;
    localparam micro_addr_t UADDR_SLTI   = 6'd15;
    localparam micro_addr_t UADDR_SLTIU  = 6'd16;
    localparam micro_addr_t UADDR_XORI   = 6'd17;
    localparam micro_addr_t UADDR_ORI    = 6'd18;
    localparam micro_addr_t UADDR_ANDI   = 6'd19;
    localparam micro_addr_t UADDR_SLLI   = 6'd20;
    localparam micro_addr_t UADDR_SRLI   = 6'd21;
    localparam micro_addr_t UADDR_SRAI   = 6'd22;
    localparam micro_addr_t UADDR_LUI    = 6'd23;
    localparam micro_addr_t UADDR_AUIPC  = 6'd24;
    localparam micro_addr_t UADDR_JAL    = 6'd25;
    localparam micro_addr_t UADDR_JALR   = 6'd26;
    localparam micro_addr_t UADDR_MUL    = 6'd27;
    localparam micro_addr_t UADDR_DIV    = 6'd28;
    localparam micro_addr_t UADDR_REM    = 6'd29;
    localparam micro_addr_t UADDR_TRAP   = 6'd63;

    // Continuation steps of multi-word instructions
    localparam micro_addr_t UADDR_LOAD_2   = 6'd32;
    localparam micro_addr_t UADDR_STORE_2  = 6'd33;
    localparam micro_addr_t UADDR_BRANCH_2 = 6'd34;
    localparam micro_addr_t UADDR_JAL_2    = 6'd35;
    localparam micro_addr_t UADDR_JALR_2   = 6'd36;
    localparam micro_addr_t UADDR_MUL_2    = 6'd37;
    localparam micro_addr_t UADDR_MUL_3    = 6'd38;
    localparam micro_addr_t UADDR_DIV_2    = 6'd39;
    localparam micro_addr_t UADDR_DIV_3    = 6'd40;
    localparam micro_addr_t UADDR_REM_2    = 6'd41;
    localparam micro_addr_t UADDR_REM_3    = 6'd42;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_SLT, ALU_SLTU, ALU_MUL, ALU_DIV, ALU_REM, ALU_PASS
    } alu_op_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        src_b_imm;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        jump;
        logic        trap;
        logic        last;          // Final micro-op of the instruction
        micro_addr_t next_address;  // Successor when last is clear
    } micro_instr_t;

    typedef struct packed {
        micro_addr_t  micro_address;
        micro_instr_t uop;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [11:0]  operand_b;
    } ctrl_word_t;

endpackage
